//--- list.f
+incdir+source
source/opnbBusPkg.sv
source/opnbRegPkg.sv
source/cpuPort.sv
source/regFile.sv
source/timerUnit.sv
source/ssgTone.sv
source/opnbCore.sv
tests/opnbCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the opnbCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module opnbCoreTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VopnbCoreTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

//--- tests/opnbCoreTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "opnb_macros.svh"

module opnbCoreTb;
	import opnbBusPkg::*;
	import opnbRegPkg::*;

	localparam int BusyCycles = `OPNB_BUSY_CYCLES;
	localparam int TimerPre = `OPNB_TIMER_PRESCALE;
	localparam int TimerBStep = `OPNB_TIMER_PRESCALE * `OPNB_TIMERB_DIV;
	localparam int SsgPre = `OPNB_SSG_PRESCALE;

	logic PHI_S;
	logic nRESET;
	logic nCs;
	logic nWr;
	logic nRd;
	portSel_t addr;
	busData_t dataIn;
	busData_t dataOut;
	logic dataDrive;
	logic nIrq;
	anaLevel_t ana;

	int errors;
	int timeouts;
	logic [31:0] lcgState;

	// Expectations armed by the stimulus
	logic resetCheck;
	logic irqCheck;
	logic anaCheck;
	anaLevel_t anaExp;
	logic statusCheck;
	busData_t statusMask;
	busData_t statusExp;
	logic toneCheck;
	anaLevel_t toneVol;
	int expGap;
	logic windowDone;
	int waitCycles;
	int winLo;
	int winHi;

	// Observers
	int busyRun;
	anaLevel_t anaPrev;
	int gap;
	int changeCount;

	opnbCore u_dut (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.nCs(nCs),
		.nWr(nWr),
		.nRd(nRd),
		.addr(addr),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.dataDrive(dataDrive),
		.nIrq(nIrq),
		.ana(ana)
	);

	initial
	begin
		PHI_S = 1'b0;
		forever #5 PHI_S = ~PHI_S;
	end

	always @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
		begin
			busyRun <= 0;
			anaPrev <= '0;
			gap <= 0;
			changeCount <= 0;
		end
		else
		begin
			busyRun <= dataOut[7] ? busyRun + 1 : 0;
			anaPrev <= ana;
			gap <= (ana != anaPrev) ? 1 : gap + 1;
			if (!toneCheck)
				changeCount <= 0;
			else if (ana != anaPrev)
				changeCount <= changeCount + 1;
		end
	end

	resetQuiet: assert property (@(posedge PHI_S) disable iff (!nRESET)
		resetCheck |-> (nIrq && !dataDrive && ana == '0))
		else
		begin
			errors++;
			$display("[ERROR] reset state nIrq %h dataDrive %h ana %h", nIrq, dataDrive, ana);
		end

	busyStart: assert property (@(posedge PHI_S) disable iff (!nRESET)
		(!nCs && !nWr && !dataOut[7]) |=> dataOut[7])
		else
		begin
			errors++;
			$display("[ERROR] dataOut[7] after write got %h expected %h", dataOut[7], 1'b1);
		end

	busyLength: assert property (@(posedge PHI_S) disable iff (!nRESET)
		$fell(dataOut[7]) |-> busyRun == BusyCycles)
		else
		begin
			errors++;
			$display("[ERROR] busy length got %h expected %h", busyRun, BusyCycles);
		end

	statusValue: assert property (@(posedge PHI_S) disable iff (!nRESET)
		(statusCheck && !nCs && !nRd) |->
			(dataDrive && (dataOut & statusMask) == statusExp))
		else
		begin
			errors++;
			$display("[ERROR] dataOut got %h expected %h under mask %h, dataDrive %h",
				dataOut, statusExp, statusMask, dataDrive);
		end

	irqLevel: assert property (@(posedge PHI_S) disable iff (!nRESET)
		irqCheck |-> nIrq)
		else
		begin
			errors++;
			$display("[ERROR] nIrq got %h expected %h", nIrq, 1'b1);
		end

	irqWindow: assert property (@(posedge PHI_S) disable iff (!nRESET)
		windowDone |-> (waitCycles >= winLo && waitCycles <= winHi))
		else
		begin
			errors++;
			$display("[ERROR] nIrq fall cycle got %h expected %h to %h",
				waitCycles, winLo, winHi);
		end

	anaLevel: assert property (@(posedge PHI_S) disable iff (!nRESET)
		anaCheck |-> ana == anaExp)
		else
		begin
			errors++;
			$display("[ERROR] ana got %h expected %h", ana, anaExp);
		end

	toneLevels: assert property (@(posedge PHI_S) disable iff (!nRESET)
		toneCheck |-> (ana == '0 || ana == toneVol))
		else
		begin
			errors++;
			$display("[ERROR] ana got %h expected 00 or %h", ana, toneVol);
		end

	// Gap only counts once two full periods have been seen
	toneSpacing: assert property (@(posedge PHI_S) disable iff (!nRESET)
		(toneCheck && changeCount >= 2 && ana != anaPrev) |-> gap == expGap)
		else
		begin
			errors++;
			$display("[ERROR] ana change gap got %h expected %h", gap, expGap);
		end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic idleCycles(input int n);
		repeat (n) @(posedge PHI_S);
		#1;
	endtask

	task automatic readStatus(output busData_t value);
		@(posedge PHI_S);
		#1;
		nCs = 1'b0;
		nRd = 1'b0;
		@(posedge PHI_S);
		#1;
		value = dataOut;
		nCs = 1'b1;
		nRd = 1'b1;
	endtask

	task automatic waitNotBusy();
		busData_t status;
		int n;
		n = 0;
		status = 8'h80;
		while (status[7] && n < 4 * BusyCycles)
		begin
			readStatus(status);
			n++;
		end
		if (status[7])
		begin
			timeouts++;
			$display("Timeout: busy flag never cleared");
		end
	endtask

	// Single strobe, no busy wait
	task automatic rawWrite(input portSel_t sel, input busData_t data);
		@(posedge PHI_S);
		#1;
		addr = sel;
		dataIn = data;
		nCs = 1'b0;
		nWr = 1'b0;
		@(posedge PHI_S);
		#1;
		nCs = 1'b1;
		nWr = 1'b1;
	endtask

	task automatic busWrite(input portSel_t sel, input busData_t data);
		waitNotBusy();
		rawWrite(sel, data);
	endtask

	task automatic writeReg(input logic bank, input regAddr_t address, input busData_t data);
		busWrite({bank, 1'b0}, address);
		busWrite({bank, 1'b1}, data);
	endtask

	task automatic waitIrqWindow(input int steps, input int stepLen);
		int n;
		int limit;
		n = 0;
		limit = stepLen * (steps + 2) + 20;
		while (nIrq && n < limit)
		begin
			@(posedge PHI_S);
			#1;
			n++;
		end
		if (nIrq)
		begin
			timeouts++;
			$display("Timeout: interrupt never asserted");
		end
		else
		begin
			waitCycles = n;
			winLo = stepLen * steps - TimerPre;
			winHi = stepLen * steps + TimerPre;
			windowDone = 1'b1;
			@(posedge PHI_S);
			#1;
			windowDone = 1'b0;
		end
	endtask

	task automatic waitToneChanges(input int count);
		int n;
		n = 0;
		while (changeCount < count && n < (count + 2) * expGap + 50)
		begin
			@(posedge PHI_S);
			#1;
			n++;
		end
		if (changeCount < count)
		begin
			timeouts++;
			$display("Timeout: tone output stopped changing");
		end
	endtask

	initial
	begin
		busData_t status;
		timerALoad_t loadA;
		timerBLoad_t loadB;
		tonePeriod_t period;
		volume_t vol;
		volume_t mixVol [3];

		nRESET = 1'b0;
		nCs = 1'b1;
		nWr = 1'b1;
		nRd = 1'b1;
		addr = '0;
		dataIn = '0;
		errors = 0;
		timeouts = 0;
		lcgState = 32'h1ce5_02fb;
		resetCheck = 1'b0;
		irqCheck = 1'b0;
		anaCheck = 1'b0;
		anaExp = '0;
		statusCheck = 1'b0;
		statusMask = '0;
		statusExp = '0;
		toneCheck = 1'b0;
		toneVol = '0;
		expGap = 1;
		windowDone = 1'b0;
		waitCycles = 0;
		winLo = 0;
		winHi = 0;

		repeat (5) @(posedge PHI_S);
		#1;
		nRESET = 1'b1;

		resetCheck = 1'b1;
		idleCycles(4);
		resetCheck = 1'b0;
		statusMask = 8'hFF;
		statusExp = 8'h00;
		statusCheck = 1'b1;
		readStatus(status);
		statusCheck = 1'b0;

		// Data write during busy must be dropped
		writeReg(1'b0, `OPNB_REG_MIXER, 8'h07);
		busWrite(2'b00, `OPNB_REG_VOL_A);
		rawWrite(2'b01, 8'h0F);
		anaExp = '0;
		anaCheck = 1'b1;
		idleCycles(BusyCycles + 10);
		anaCheck = 1'b0;

		loadA = timerALoad_t'(nextRand() >> 8);
		writeReg(1'b0, `OPNB_REG_TIMER_A_HI, loadA[9:2]);
		writeReg(1'b0, `OPNB_REG_TIMER_A_LO, {6'b000000, loadA[1:0]});
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h05);
		waitIrqWindow(1024 - int'(loadA), TimerPre);
		statusMask = 8'h03;
		statusExp = 8'h01;
		statusCheck = 1'b1;
		readStatus(status);
		statusCheck = 1'b0;
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h10);
		idleCycles(3);
		irqCheck = 1'b1;
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h01);
		idleCycles(2 * TimerPre * (1024 - int'(loadA)) + 8);
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h00);

		// Bank B has no timer registers
		writeReg(1'b1, `OPNB_REG_TIMER_B, 8'hFF);
		writeReg(1'b1, `OPNB_REG_TIMER_CTRL, 8'h0A);
		idleCycles(4 * TimerBStep);
		irqCheck = 1'b0;

		loadB = timerBLoad_t'(nextRand() >> 8);
		writeReg(1'b0, `OPNB_REG_TIMER_B, loadB);
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h0A);
		waitIrqWindow(256 - int'(loadB), TimerBStep);
		statusMask = 8'h03;
		statusExp = 8'h02;
		statusCheck = 1'b1;
		readStatus(status);
		statusCheck = 1'b0;
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h20);
		idleCycles(3);
		irqCheck = 1'b1;
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h02);
		idleCycles(2 * TimerBStep * (256 - int'(loadB)) + 8);
		writeReg(1'b0, `OPNB_REG_TIMER_CTRL, 8'h00);
		irqCheck = 1'b0;

		// Tone A alone, B and C keep volume 0
		period = tonePeriod_t'(nextRand() % 40 + 1);
		vol = volume_t'(nextRand() % 15 + 1);
		writeReg(1'b0, `OPNB_REG_MIXER, 8'h06);
		writeReg(1'b0, `OPNB_REG_TONE_A_LO, period[7:0]);
		writeReg(1'b0, `OPNB_REG_TONE_A_HI, {4'b0000, period[11:8]});
		writeReg(1'b0, `OPNB_REG_VOL_A, {4'b0000, vol});
		idleCycles(3);
		toneVol = anaLevel_t'(vol);
		expGap = int'(period) * SsgPre;
		toneCheck = 1'b1;
		waitToneChanges(6);
		toneCheck = 1'b0;

		for (int i = 0; i < 3; i++)
			mixVol[i] = volume_t'(nextRand() >> 12);
		writeReg(1'b0, `OPNB_REG_MIXER, 8'h07);
		writeReg(1'b0, `OPNB_REG_VOL_A, {4'b0000, mixVol[0]});
		writeReg(1'b0, `OPNB_REG_VOL_B, {4'b0000, mixVol[1]});
		writeReg(1'b0, `OPNB_REG_VOL_C, {4'b0000, mixVol[2]});
		idleCycles(3);
		anaExp = anaLevel_t'(mixVol[0]) + anaLevel_t'(mixVol[1]) + anaLevel_t'(mixVol[2]);
		anaCheck = 1'b1;
		idleCycles(20);
		anaCheck = 1'b0;

		$display("Checks done: errors=%0d timeouts=%0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog for the whole run
	initial
	begin
		#2_000_000;
		$display("Timeout: simulation did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/opnbCore.sv
`timescale 1ns/10ps
`default_nettype none

module opnbCore (
	input  wire logic                  PHI_S,
	input  wire logic                  nRESET,
	input  wire logic                  nCs,
	input  wire logic                  nWr,
	input  wire logic                  nRd,
	input  wire opnbBusPkg::portSel_t  addr,
	input  wire opnbBusPkg::busData_t  dataIn,
	output opnbBusPkg::busData_t       dataOut,
	output logic                       dataDrive,
	output logic                       nIrq,
	output opnbRegPkg::anaLevel_t      ana
);
	import opnbBusPkg::*;
	import opnbRegPkg::*;

	cpuWrite_t regWrite;
	ssgConfig_t ssgCfg;
	timerConfig_t timerCfg;
	timerCmd_t timerCmd;
	logic [1:0] flags;

	cpuPort u_cpuPort (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.nCs(nCs),
		.nWr(nWr),
		.nRd(nRd),
		.addr(addr),
		.dataIn(dataIn),
		.flags(flags),
		.dataOut(dataOut),
		.dataDrive(dataDrive),
		.regWrite(regWrite)
	);

	regFile u_regFile (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.regWrite(regWrite),
		.ssgCfg(ssgCfg),
		.timerCfg(timerCfg),
		.timerCmd(timerCmd)
	);

	timerUnit u_timerUnit (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.timerCfg(timerCfg),
		.timerCmd(timerCmd),
		.flags(flags),
		.nIrq(nIrq)
	);

	ssgTone u_ssgTone (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.ssgCfg(ssgCfg),
		.ana(ana)
	);

endmodule

`default_nettype wire

//--- source/ssgTone.sv
`timescale 1ns/10ps
`default_nettype none
`include "opnb_macros.svh"

module ssgTone (
	input  wire logic                    PHI_S,
	input  wire logic                    nRESET,
	input  wire opnbRegPkg::ssgConfig_t  ssgCfg,
	output opnbRegPkg::anaLevel_t        ana
);
	import opnbRegPkg::*;

	localparam int Prescale = `OPNB_SSG_PRESCALE;
	localparam int PreW = (Prescale > 1) ? $clog2(Prescale) : 1;

	logic [PreW-1:0] preCount;
	logic stepEn;
	tonePeriod_t [2:0] toneCount;
	logic [2:0] toneBit;
	anaLevel_t mixSum;

	// Period 0 behaves like period 1
	function automatic tonePeriod_t reloadOf(input tonePeriod_t period);
		return (period == '0) ? '0 : period - 1'b1;
	endfunction

	assign stepEn = (preCount == PreW'(Prescale - 1));

	always_ff @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
		begin
			preCount <= '0;
			toneCount <= '0;
			toneBit <= '0;
		end
		else
		begin
			preCount <= stepEn ? '0 : preCount + 1'b1;
			if (stepEn)
			begin
				for (int i = 0; i < 3; i++)
				begin
					if (toneCount[i] == '0)
					begin
						toneCount[i] <= reloadOf(ssgCfg.period[i]);
						toneBit[i] <= ~toneBit[i];
					end
					else
						toneCount[i] <= toneCount[i] - 1'b1;
				end
			end
		end
	end

	// Masked channel contributes its full volume
	always_comb
	begin
		mixSum = '0;
		for (int i = 0; i < 3; i++)
			if (toneBit[i] || ssgCfg.toneOff[i])
				mixSum = mixSum + anaLevel_t'(ssgCfg.volume[i]);
	end

	always_ff @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
			ana <= '0;
		else
			ana <= mixSum;
	end

endmodule

`default_nettype wire

//--- source/timerUnit.sv
`timescale 1ns/10ps
`default_nettype none
`include "opnb_macros.svh"

module timerUnit (
	input  wire logic                      PHI_S,
	input  wire logic                      nRESET,
	input  wire opnbRegPkg::timerConfig_t  timerCfg,
	input  wire opnbRegPkg::timerCmd_t     timerCmd,
	output logic [1:0]                     flags,
	output logic                           nIrq
);
	import opnbRegPkg::*;

	localparam int Prescale = `OPNB_TIMER_PRESCALE;
	localparam int TimerBDiv = `OPNB_TIMERB_DIV;
	localparam int PreW = (Prescale > 1) ? $clog2(Prescale) : 1;
	localparam int DivW = (TimerBDiv > 1) ? $clog2(TimerBDiv) : 1;

	logic [PreW-1:0] preCount;
	logic [DivW-1:0] divCount;
	logic tickA;
	logic tickB;
	timerALoad_t countA;
	timerBLoad_t countB;
	logic overflowA;
	logic overflowB;

	assign tickA = (preCount == PreW'(Prescale - 1));
	assign tickB = tickA && (divCount == DivW'(TimerBDiv - 1));
	assign overflowA = timerCfg.runA && tickA && (countA == '1);
	assign overflowB = timerCfg.runB && tickB && (countB == '1);

	always_ff @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
		begin
			preCount <= '0;
			divCount <= '0;
			countA <= '0;
			countB <= '0;
		end
		else
		begin
			preCount <= tickA ? '0 : preCount + 1'b1;
			// Stopped counters sit on their load value
			if (!timerCfg.runA)
				countA <= timerCfg.loadA;
			else if (tickA)
				countA <= (countA == '1) ? timerCfg.loadA : countA + 1'b1;
			if (!timerCfg.runB)
			begin
				divCount <= '0;
				countB <= timerCfg.loadB;
			end
			else if (tickA)
			begin
				divCount <= tickB ? '0 : divCount + 1'b1;
				if (tickB)
					countB <= (countB == '1) ? timerCfg.loadB : countB + 1'b1;
			end
		end
	end

	// Overflow wins over a clear in the same cycle
	always_ff @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
			flags <= '0;
		else
		begin
			if (overflowA && timerCfg.irqEnA)
				flags[0] <= 1'b1;
			else if (timerCmd.clearA)
				flags[0] <= 1'b0;
			if (overflowB && timerCfg.irqEnB)
				flags[1] <= 1'b1;
			else if (timerCmd.clearB)
				flags[1] <= 1'b0;
		end
	end

	assign nIrq = !(|flags);

	// Interrupt stays asserted until a clear strobe
	irqHold: assert property (@(posedge PHI_S) disable iff (!nRESET)
		(!nIrq && !(|timerCmd)) |=> !nIrq)
		else $error("[ERROR] nIrq released without a clear strobe, flags %h", flags);

endmodule

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/10ps
`default_nettype none
`include "opnb_macros.svh"

module regFile (
	input  wire logic                   PHI_S,
	input  wire logic                   nRESET,
	input  wire opnbBusPkg::cpuWrite_t  regWrite,
	output opnbRegPkg::ssgConfig_t      ssgCfg,
	output opnbRegPkg::timerConfig_t    timerCfg,
	output opnbRegPkg::timerCmd_t       timerCmd
);
	import opnbRegPkg::*;

	regAddr_t addrLatch;

	always_ff @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
		begin
			addrLatch <= '0;
			ssgCfg <= '0;
			timerCfg <= '0;
			timerCmd <= '0;
		end
		else
		begin
			// Flag resets are strobes, never stored
			timerCmd <= '0;
			if (regWrite.valid)
			begin
				if (!regWrite.sel[0])
					addrLatch <= regAddr_t'(regWrite.data);
				else if (!regWrite.sel[1])
				begin
					case (addrLatch)
						`OPNB_REG_TONE_A_LO: ssgCfg.period[0][7:0] <= regWrite.data;
						`OPNB_REG_TONE_A_HI: ssgCfg.period[0][11:8] <= regWrite.data[3:0];
						`OPNB_REG_TONE_B_LO: ssgCfg.period[1][7:0] <= regWrite.data;
						`OPNB_REG_TONE_B_HI: ssgCfg.period[1][11:8] <= regWrite.data[3:0];
						`OPNB_REG_TONE_C_LO: ssgCfg.period[2][7:0] <= regWrite.data;
						`OPNB_REG_TONE_C_HI: ssgCfg.period[2][11:8] <= regWrite.data[3:0];
						`OPNB_REG_MIXER:     ssgCfg.toneOff <= regWrite.data[2:0];
						`OPNB_REG_VOL_A:     ssgCfg.volume[0] <= regWrite.data[3:0];
						`OPNB_REG_VOL_B:     ssgCfg.volume[1] <= regWrite.data[3:0];
						`OPNB_REG_VOL_C:     ssgCfg.volume[2] <= regWrite.data[3:0];
						`OPNB_REG_TIMER_A_HI: timerCfg.loadA[9:2] <= regWrite.data;
						`OPNB_REG_TIMER_A_LO: timerCfg.loadA[1:0] <= regWrite.data[1:0];
						`OPNB_REG_TIMER_B:   timerCfg.loadB <= regWrite.data;
						`OPNB_REG_TIMER_CTRL:
						begin
							timerCfg.runA <= regWrite.data[0];
							timerCfg.runB <= regWrite.data[1];
							timerCfg.irqEnA <= regWrite.data[2];
							timerCfg.irqEnB <= regWrite.data[3];
							timerCmd.clearA <= regWrite.data[4];
							timerCmd.clearB <= regWrite.data[5];
						end
						default:
							;
					endcase
				end
			end
		end
	end

	// Relies on the port presenting each write for one cycle only
	cmdPulse: assert property (@(posedge PHI_S) disable iff (!nRESET)
		(|timerCmd) |=> !(|timerCmd))
		else $error("[ERROR] timerCmd high for two cycles, value %h", timerCmd);

endmodule

`default_nettype wire

//--- source/cpuPort.sv
`timescale 1ns/10ps
`default_nettype none
`include "opnb_macros.svh"

module cpuPort (
	input  wire logic                  PHI_S,
	input  wire logic                  nRESET,
	input  wire logic                  nCs,
	input  wire logic                  nWr,
	input  wire logic                  nRd,
	input  wire opnbBusPkg::portSel_t  addr,
	input  wire opnbBusPkg::busData_t  dataIn,
	input  wire logic [1:0]            flags,
	output opnbBusPkg::busData_t       dataOut,
	output logic                       dataDrive,
	output opnbBusPkg::cpuWrite_t      regWrite
);
	import opnbBusPkg::*;

	localparam int BusyCycles = `OPNB_BUSY_CYCLES;
	localparam int CountW = (BusyCycles > 1) ? $clog2(BusyCycles) : 1;

	typedef logic [CountW-1:0] busyCount_t;

	portState_t state;
	busyCount_t busyCount;
	cpuWrite_t captured;
	logic busy;
	logic writeReq;

	assign busy = (state == portBusy);
	assign writeReq = !nCs && !nWr && !busy;

	// Busy window, one accepted write each
	always_ff @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state <= portIdle;
			busyCount <= '0;
		end
		else
		begin
			case (state)
				portIdle:
					if (writeReq)
					begin
						state <= portBusy;
						busyCount <= busyCount_t'(BusyCycles - 1);
					end
				portBusy:
					if (busyCount == '0)
						state <= portIdle;
					else
						busyCount <= busyCount - 1'b1;
				default:
					state <= portIdle;
			endcase
		end
	end

	// Capture, then hand over one cycle later
	always_ff @(posedge PHI_S or negedge nRESET)
	begin
		if (!nRESET)
		begin
			captured <= '0;
			regWrite <= '0;
		end
		else
		begin
			captured.valid <= writeReq;
			if (writeReq)
			begin
				captured.sel <= addr;
				captured.data <= dataIn;
			end
			regWrite <= captured;
		end
	end

	// Status byte, same for every port value
	assign dataDrive = !nCs && !nRd;
	assign dataOut = {busy, 5'b00000, flags};

	busyLength: assert property (@(posedge PHI_S) disable iff (!nRESET)
		$rose(busy) |-> ##[1:BusyCycles] !busy)
		else $error("[ERROR] busy high longer than %0d cycles", BusyCycles);

endmodule

`default_nettype wire

//--- source/opnbRegPkg.sv
`default_nettype none

package opnbRegPkg;

	typedef logic [7:0]  regAddr_t;
	typedef logic [11:0] tonePeriod_t;
	typedef logic [3:0]  volume_t;
	typedef logic [9:0]  timerALoad_t;
	typedef logic [7:0]  timerBLoad_t;
	typedef logic [5:0]  anaLevel_t;

	// Index 0 is channel A
	typedef struct packed {
		tonePeriod_t [2:0] period;
		logic [2:0]        toneOff;
		volume_t [2:0]     volume;
	} ssgConfig_t;

	typedef struct packed {
		timerALoad_t loadA;
		timerBLoad_t loadB;
		logic        runA;
		logic        runB;
		logic        irqEnA;
		logic        irqEnB;
	} timerConfig_t;

	typedef struct packed {
		logic clearA;
		logic clearB;
	} timerCmd_t;

endpackage

`default_nettype wire

//--- source/opnbBusPkg.sv
`default_nettype none

package opnbBusPkg;

	// Bit 0 selects data, bit 1 selects bank B
	typedef logic [1:0] portSel_t;

	typedef logic [7:0] busData_t;

	// Write as captured from the host bus
	typedef struct packed {
		logic     valid;
		portSel_t sel;
		busData_t data;
	} cpuWrite_t;

	typedef enum logic {
		portIdle,
		portBusy
	} portState_t;

endpackage

`default_nettype wire

//--- source/opnb_macros.svh
`ifndef OPNB_MACROS_SVH
`define OPNB_MACROS_SVH

`define OPNB_BUSY_CYCLES      8
`define OPNB_TIMER_PRESCALE   4
`define OPNB_TIMERB_DIV       16
`define OPNB_SSG_PRESCALE     2

// Register map, bank A
`define OPNB_REG_TONE_A_LO    8'h00
`define OPNB_REG_TONE_A_HI    8'h01
`define OPNB_REG_TONE_B_LO    8'h02
`define OPNB_REG_TONE_B_HI    8'h03
`define OPNB_REG_TONE_C_LO    8'h04
`define OPNB_REG_TONE_C_HI    8'h05
`define OPNB_REG_MIXER        8'h07
`define OPNB_REG_VOL_A        8'h08
`define OPNB_REG_VOL_B        8'h09
`define OPNB_REG_VOL_C        8'h0A
`define OPNB_REG_TIMER_A_HI   8'h24
`define OPNB_REG_TIMER_A_LO   8'h25
`define OPNB_REG_TIMER_B      8'h26
`define OPNB_REG_TIMER_CTRL   8'h27

`endif
